// ==== nco_pkg.sv ====
`default_nettype none

package nco_pkg;

    // Phase accumulator and table addressing
    localparam int PHASE_WIDTH = 12;
    localparam int TABLE_DEPTH = 4096;

    // Sine lags cosine by a quarter turn
    localparam int QUARTER_TURN = TABLE_DEPTH / 4;

    // Signed coefficient format
    localparam int COEF_WIDTH = 18;
    localparam int COEF_AMPLITUDE = 131071;

    localparam real PI = 3.14159265358979323846;

    // Rounded cosine for one table index, also used by the testbench model
    function automatic logic signed [COEF_WIDTH-1:0] cos_coef(
        input int index
    );
        int  wrapped;
        real angle;
        real value;

        wrapped = index % TABLE_DEPTH;
        if (wrapped < 0) begin
            wrapped = wrapped + TABLE_DEPTH;
        end
        angle = 2.0 * PI * real'(wrapped) / real'(TABLE_DEPTH);
        value = real'(COEF_AMPLITUDE) * $cos(angle);

        // Cast to int rounds to nearest
        return COEF_WIDTH'(int'(value));
    endfunction

endpackage : nco_pkg

`default_nettype wire

// ==== chmod_pkg.sv ====
`default_nettype none

package chmod_pkg;

    // Signed I/Q sample format
    localparam int SAMPLE_WIDTH = 16;
    localparam int SAMPLE_MAX = (2 ** (SAMPLE_WIDTH - 1)) - 1;
    localparam int SAMPLE_MIN = -(2 ** (SAMPLE_WIDTH - 1));

    // Mixer arithmetic widths
    localparam int PRODUCT_WIDTH = SAMPLE_WIDTH + nco_pkg::COEF_WIDTH;
    localparam int SUM_WIDTH = PRODUCT_WIDTH + 1;

    // Output scaling back to sample range
    localparam int OUT_SHIFT = 17;
    localparam int SCALED_WIDTH = SUM_WIDTH - OUT_SHIFT;

    // Half an output LSB, round to nearest
    localparam int ROUND_BIAS = 2 ** (OUT_SHIFT - 1);

    // IQ reordering applied at the front stage
    typedef enum logic [1:0] {
        IQ_PASS = 2'd0,
        IQ_SWAP = 2'd1,
        IQ_CONJ = 2'd2
    } iq_op_e;

    // Rotation sense of the mixer
    typedef enum logic {
        DIR_UP   = 1'b0,
        DIR_DOWN = 1'b1
    } mix_dir_e;

endpackage : chmod_pkg

`default_nettype wire

// ==== chmod_nco.sv ====
`timescale 1ns/1ps

`default_nettype none

module chmod_nco (
    input  wire logic                                  i_clock,
    input  wire logic                                  i_rst_n,
    input  wire logic [nco_pkg::PHASE_WIDTH-1:0]       i_phase_inc,
    input  wire logic                                  i_phase_inc_valid,
    input  wire logic                                  i_valid,
    input  wire chmod_pkg::mix_dir_e                   i_mix_dir,
    output      logic signed [nco_pkg::COEF_WIDTH-1:0] o_coef_cos,
    output      logic signed [nco_pkg::COEF_WIDTH-1:0] o_coef_sin,
    output      logic                                  o_coef_valid
);

    import nco_pkg::*;
    import chmod_pkg::*;

    logic [PHASE_WIDTH-1:0]       phase_inc;
    logic [PHASE_WIDTH-1:0]       phase_acc;
    logic [PHASE_WIDTH-1:0]       cos_index;
    logic [PHASE_WIDTH-1:0]       sin_index;
    logic signed [COEF_WIDTH-1:0] cos_table [TABLE_DEPTH];
    logic signed [COEF_WIDTH-1:0] cos_value;
    logic signed [COEF_WIDTH-1:0] sin_value;

    // Full-period cosine ROM
    for (genvar k = 0; k < TABLE_DEPTH; k++) begin : g_table
        assign cos_table[k] = cos_coef(k);
    end

    // A load in the same cycle forces phase zero
    assign cos_index = i_phase_inc_valid ? '0 : phase_acc;

    // Wraps modulo table depth
    assign sin_index = cos_index - PHASE_WIDTH'(QUARTER_TURN);

    assign cos_value = cos_table[cos_index];
    assign sin_value = cos_table[sin_index];

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            phase_inc <= '0;
            phase_acc <= '0;
        end else if (i_phase_inc_valid) begin
            phase_inc <= i_phase_inc;
            phase_acc <= '0;
        end else if (i_valid) begin
            phase_acc <= phase_acc + phase_inc;
        end
    end

    // Downconversion uses the conjugate rotation
    always_ff @(posedge i_clock) begin
        if (i_valid) begin
            o_coef_cos <= cos_value;
            if (i_mix_dir == DIR_DOWN) begin
                o_coef_sin <= -sin_value;
            end else begin
                o_coef_sin <= sin_value;
            end
        end
    end

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_coef_valid <= 1'b0;
        end else begin
            o_coef_valid <= i_valid;
        end
    end

endmodule : chmod_nco

`default_nettype wire

// ==== chmod_iq_front.sv ====
`timescale 1ns/1ps

`default_nettype none

module chmod_iq_front (
    input  wire logic                                      i_clock,
    input  wire logic                                      i_rst_n,
    input  wire logic signed [chmod_pkg::SAMPLE_WIDTH-1:0] i_inph,
    input  wire logic signed [chmod_pkg::SAMPLE_WIDTH-1:0] i_quad,
    input  wire logic                                      i_valid,
    input  wire chmod_pkg::iq_op_e                         i_iq_op,
    output      logic signed [chmod_pkg::SAMPLE_WIDTH-1:0] o_inph,
    output      logic signed [chmod_pkg::SAMPLE_WIDTH-1:0] o_quad,
    output      logic                                      o_valid
);

    import chmod_pkg::*;

    logic signed [SAMPLE_WIDTH-1:0] next_inph;
    logic signed [SAMPLE_WIDTH-1:0] next_quad;

    // Most negative input maps to most positive
    function automatic logic signed [SAMPLE_WIDTH-1:0] neg_sat(
        input logic signed [SAMPLE_WIDTH-1:0] value
    );
        if (value == SAMPLE_MIN) begin
            return SAMPLE_WIDTH'(SAMPLE_MAX);
        end
        return -value;
    endfunction

    always_comb begin
        next_inph = i_inph;
        next_quad = i_quad;
        case (i_iq_op)
            IQ_SWAP: begin
                next_inph = i_quad;
                next_quad = i_inph;
            end
            IQ_CONJ: begin
                next_quad = neg_sat(i_quad);
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_valid) begin
            o_inph <= next_inph;
            o_quad <= next_quad;
        end
    end

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

endmodule : chmod_iq_front

`default_nettype wire

// ==== chmod_mixer.sv ====
`timescale 1ns/1ps

`default_nettype none

module chmod_mixer (
    input  wire logic                                      i_clock,
    input  wire logic                                      i_rst_n,
    input  wire logic signed [chmod_pkg::SAMPLE_WIDTH-1:0] i_inph,
    input  wire logic signed [chmod_pkg::SAMPLE_WIDTH-1:0] i_quad,
    input  wire logic signed [nco_pkg::COEF_WIDTH-1:0]     i_coef_cos,
    input  wire logic signed [nco_pkg::COEF_WIDTH-1:0]     i_coef_sin,
    input  wire logic                                      i_valid,
    output      logic signed [chmod_pkg::SAMPLE_WIDTH-1:0] o_inph,
    output      logic signed [chmod_pkg::SAMPLE_WIDTH-1:0] o_quad,
    output      logic                                      o_valid
);

    import chmod_pkg::*;
    import nco_pkg::*;

    // Stage 1
    logic signed [PRODUCT_WIDTH-1:0] inph_cos_s1;
    logic signed [PRODUCT_WIDTH-1:0] inph_sin_s1;
    logic signed [SAMPLE_WIDTH-1:0]  quad_s1;
    logic signed [COEF_WIDTH-1:0]    cos_s1;
    logic signed [COEF_WIDTH-1:0]    sin_s1;
    logic                            valid_s1;

    // Stage 2
    logic signed [PRODUCT_WIDTH-1:0] inph_cos_s2;
    logic signed [PRODUCT_WIDTH-1:0] inph_sin_s2;
    logic signed [PRODUCT_WIDTH-1:0] quad_cos_s2;
    logic signed [PRODUCT_WIDTH-1:0] quad_sin_s2;
    logic                            valid_s2;

    // Output arithmetic
    logic signed [SUM_WIDTH-1:0]     sum_i;
    logic signed [SUM_WIDTH-1:0]     sum_q;
    logic signed [SCALED_WIDTH-1:0]  scaled_i;
    logic signed [SCALED_WIDTH-1:0]  scaled_q;

    function automatic logic signed [SAMPLE_WIDTH-1:0] saturate(
        input logic signed [SCALED_WIDTH-1:0] value
    );
        if (value > SAMPLE_MAX) begin
            return SAMPLE_WIDTH'(SAMPLE_MAX);
        end else if (value < SAMPLE_MIN) begin
            return SAMPLE_WIDTH'(SAMPLE_MIN);
        end
        return value[SAMPLE_WIDTH-1:0];
    endfunction

    // I products first, Q products one cycle later
    always_ff @(posedge i_clock) begin
        inph_cos_s1 <= i_inph * i_coef_cos;
        inph_sin_s1 <= i_inph * i_coef_sin;
        quad_s1     <= i_quad;
        cos_s1      <= i_coef_cos;
        sin_s1      <= i_coef_sin;

        inph_cos_s2 <= inph_cos_s1;
        inph_sin_s2 <= inph_sin_s1;
        quad_cos_s2 <= quad_s1 * cos_s1;
        quad_sin_s2 <= quad_s1 * sin_s1;
    end

    // Sign-extended sums plus rounding bias
    assign sum_i = inph_cos_s2 - quad_sin_s2 + ROUND_BIAS;
    assign sum_q = inph_sin_s2 + quad_cos_s2 + ROUND_BIAS;

    assign scaled_i = SCALED_WIDTH'(sum_i >>> OUT_SHIFT);
    assign scaled_q = SCALED_WIDTH'(sum_q >>> OUT_SHIFT);

    always_ff @(posedge i_clock) begin
        if (valid_s2) begin
            o_inph <= saturate(scaled_i);
            o_quad <= saturate(scaled_q);
        end
    end

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_s1 <= 1'b0;
            valid_s2 <= 1'b0;
            o_valid  <= 1'b0;
        end else begin
            valid_s1 <= i_valid;
            valid_s2 <= valid_s1;
            o_valid  <= valid_s2;
        end
    end

endmodule : chmod_mixer

`default_nettype wire

// ==== rx_channel_modulator.sv ====
`timescale 1ns/1ps

`default_nettype none

module rx_channel_modulator (
    input  wire logic                                      i_clock,
    input  wire logic                                      i_rst_n,
    // Sample input
    input  wire logic signed [chmod_pkg::SAMPLE_WIDTH-1:0] i_inph,
    input  wire logic signed [chmod_pkg::SAMPLE_WIDTH-1:0] i_quad,
    input  wire logic                                      i_valid,
    // Frequency control
    input  wire logic [nco_pkg::PHASE_WIDTH-1:0]           i_phase_inc,
    input  wire logic                                      i_phase_inc_valid,
    // Per-sample configuration
    input  wire chmod_pkg::iq_op_e                         i_iq_op,
    input  wire chmod_pkg::mix_dir_e                       i_mix_dir,
    // Shifted sample output
    output      logic signed [chmod_pkg::SAMPLE_WIDTH-1:0] o_inph,
    output      logic signed [chmod_pkg::SAMPLE_WIDTH-1:0] o_quad,
    output      logic                                      o_valid
);

    import chmod_pkg::*;
    import nco_pkg::*;

    logic signed [COEF_WIDTH-1:0]   coef_cos;
    logic signed [COEF_WIDTH-1:0]   coef_sin;
    logic                           coef_valid;

    logic signed [SAMPLE_WIDTH-1:0] front_inph;
    logic signed [SAMPLE_WIDTH-1:0] front_quad;
    logic                           front_valid;

    chmod_nco chmod_nco_inst (
        .i_clock          (i_clock),
        .i_rst_n          (i_rst_n),
        .i_phase_inc      (i_phase_inc),
        .i_phase_inc_valid(i_phase_inc_valid),
        .i_valid          (i_valid),
        .i_mix_dir        (i_mix_dir),
        .o_coef_cos       (coef_cos),
        .o_coef_sin       (coef_sin),
        .o_coef_valid     (coef_valid)
    );

    chmod_iq_front chmod_iq_front_inst (
        .i_clock(i_clock),
        .i_rst_n(i_rst_n),
        .i_inph (i_inph),
        .i_quad (i_quad),
        .i_valid(i_valid),
        .i_iq_op(i_iq_op),
        .o_inph (front_inph),
        .o_quad (front_quad),
        .o_valid(front_valid)
    );

    // Front stage valid paces the mixer
    chmod_mixer chmod_mixer_inst (
        .i_clock   (i_clock),
        .i_rst_n   (i_rst_n),
        .i_inph    (front_inph),
        .i_quad    (front_quad),
        .i_coef_cos(coef_cos),
        .i_coef_sin(coef_sin),
        .i_valid   (front_valid),
        .o_inph    (o_inph),
        .o_quad    (o_quad),
        .o_valid   (o_valid)
    );

endmodule : rx_channel_modulator

`default_nettype wire

// ==== rx_channel_modulator_properties.sv ====
`timescale 1ns/1ps

`default_nettype none

module rx_channel_modulator_properties (
    input wire logic i_clock,
    input wire logic i_rst_n,
    input wire logic i_valid,
    input wire logic i_out_valid,
    input wire logic i_coef_valid,
    input wire logic i_front_valid
);

    int assert_failures = 0;

    // Front or NCO stage plus three mixer stages
    a_valid_latency: assert property (
        @(posedge i_clock) disable iff (!i_rst_n)
        i_out_valid == $past(i_valid, 4)
    ) else begin
        $error("o_valid does not follow i_valid by 4 cycles");
        assert_failures++;
    end

    a_reset_quiet: assert property (
        @(posedge i_clock) !i_rst_n |-> !i_out_valid
    ) else begin
        $error("o_valid high during reset");
        assert_failures++;
    end

    a_coef_front_aligned: assert property (
        @(posedge i_clock) disable iff (!i_rst_n)
        i_coef_valid == i_front_valid
    ) else begin
        $error("coef_valid and front_valid out of step");
        assert_failures++;
    end

endmodule : rx_channel_modulator_properties

bind rx_channel_modulator rx_channel_modulator_properties rx_channel_modulator_properties_inst (
    .i_clock      (i_clock),
    .i_rst_n      (i_rst_n),
    .i_valid      (i_valid),
    .i_out_valid  (o_valid),
    .i_coef_valid (coef_valid),
    .i_front_valid(front_valid)
);

`default_nettype wire

// ==== tb_rx_channel_modulator.sv ====
`timescale 1ns/1ps

`default_nettype none

module tb_rx_channel_modulator;

    import chmod_pkg::*;
    import nco_pkg::*;

    localparam int PIPE_LATENCY = 4;
    localparam int DRAIN_TIMEOUT = 64;
    localparam logic [31:0] SEED = 32'h6320258d;

    logic                           i_clock = 1'b0;
    logic                           i_rst_n;
    logic signed [SAMPLE_WIDTH-1:0] i_inph;
    logic signed [SAMPLE_WIDTH-1:0] i_quad;
    logic                           i_valid;
    logic [PHASE_WIDTH-1:0]         i_phase_inc;
    logic                           i_phase_inc_valid;
    iq_op_e                         i_iq_op;
    mix_dir_e                       i_mix_dir;
    logic signed [SAMPLE_WIDTH-1:0] o_inph;
    logic signed [SAMPLE_WIDTH-1:0] o_quad;
    logic                           o_valid;

    // Model state and expected results
    int                             model_inc = 0;
    int                             model_acc = 0;
    logic signed [SAMPLE_WIDTH-1:0] exp_i_q [$];
    logic signed [SAMPLE_WIDTH-1:0] exp_q_q [$];
    int                             in_cycle_q [$];

    int cycle_count = 0;
    int error_count = 0;
    int sent_count = 0;
    int out_count = 0;
    int test_count = 0;
    int seed_value;

    always #2 i_clock = ~i_clock;

    always @(posedge i_clock) begin
        cycle_count <= cycle_count + 1;
    end

    rx_channel_modulator rx_channel_modulator_inst (
        .i_clock          (i_clock),
        .i_rst_n          (i_rst_n),
        .i_inph           (i_inph),
        .i_quad           (i_quad),
        .i_valid          (i_valid),
        .i_phase_inc      (i_phase_inc),
        .i_phase_inc_valid(i_phase_inc_valid),
        .i_iq_op          (i_iq_op),
        .i_mix_dir        (i_mix_dir),
        .o_inph           (o_inph),
        .o_quad           (o_quad),
        .o_valid          (o_valid)
    );

    task automatic compare_sample(
        input logic signed [SAMPLE_WIDTH-1:0] actual,
        input logic signed [SAMPLE_WIDTH-1:0] expected,
        input string                          what
    );
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s got %0d, expected %0d",
                     $time, what, actual, expected);
            error_count++;
        end
    endtask

    task automatic check_latency(input int latency);
        if (latency != PIPE_LATENCY) begin
            $display("CHECK FAILED at %0t ns: latency %0d cycles, expected %0d",
                     $time, latency, PIPE_LATENCY);
            error_count++;
        end
    endtask

    // Half LSB bias, arithmetic shift, clamp to sample range
    function automatic logic signed [SAMPLE_WIDTH-1:0] round_saturate(input longint sum);
        longint scaled;
        scaled = (sum + (longint'(1) <<< (OUT_SHIFT - 1))) >>> OUT_SHIFT;
        if (scaled > SAMPLE_MAX) begin
            return SAMPLE_WIDTH'(SAMPLE_MAX);
        end else if (scaled < SAMPLE_MIN) begin
            return SAMPLE_WIDTH'(SAMPLE_MIN);
        end
        return SAMPLE_WIDTH'(scaled);
    endfunction

    task automatic predict_sample(
        input int       inph,
        input int       quad,
        input iq_op_e   op,
        input mix_dir_e dir,
        input int       phase
    );
        int     front_i;
        int     front_q;
        int     cos_v;
        int     sin_v;
        longint sum_i;
        longint sum_q;
        front_i = inph;
        front_q = quad;
        if (op == IQ_SWAP) begin
            front_i = quad;
            front_q = inph;
        end else if (op == IQ_CONJ) begin
            front_q = (quad == SAMPLE_MIN) ? SAMPLE_MAX : -quad;
        end
        cos_v = cos_coef(phase);
        sin_v = cos_coef(phase - TABLE_DEPTH / 4);
        if (dir == DIR_DOWN) begin
            sin_v = -sin_v;
        end
        sum_i = longint'(front_i) * cos_v - longint'(front_q) * sin_v;
        sum_q = longint'(front_i) * sin_v + longint'(front_q) * cos_v;
        exp_i_q.push_back(round_saturate(sum_i));
        exp_q_q.push_back(round_saturate(sum_q));
        in_cycle_q.push_back(cycle_count);
        sent_count++;
    endtask

    // One falling-edge drive, model follows the NCO phase rules
    task automatic drive_cycle(
        input logic                           valid,
        input logic signed [SAMPLE_WIDTH-1:0] inph,
        input logic signed [SAMPLE_WIDTH-1:0] quad,
        input iq_op_e                         op,
        input mix_dir_e                       dir,
        input logic                           load,
        input logic [PHASE_WIDTH-1:0]         inc
    );
        @(negedge i_clock);
        i_valid           = valid;
        i_inph            = inph;
        i_quad            = quad;
        i_iq_op           = op;
        i_mix_dir         = dir;
        i_phase_inc_valid = load;
        i_phase_inc       = inc;
        if (valid) begin
            predict_sample(inph, quad, op, dir, load ? 0 : model_acc);
        end
        if (load) begin
            model_inc = inc;
            model_acc = 0;
        end else if (valid) begin
            model_acc = (model_acc + model_inc) % TABLE_DEPTH;
        end
    endtask

    task automatic send_sample(
        input logic signed [SAMPLE_WIDTH-1:0] inph,
        input logic signed [SAMPLE_WIDTH-1:0] quad,
        input iq_op_e                         op,
        input mix_dir_e                       dir
    );
        drive_cycle(1'b1, inph, quad, op, dir, 1'b0, '0);
    endtask

    task automatic load_increment(input logic [PHASE_WIDTH-1:0] inc);
        drive_cycle(1'b0, '0, '0, IQ_PASS, DIR_UP, 1'b1, inc);
    endtask

    task automatic idle_cycles(input int count);
        repeat (count) begin
            drive_cycle(1'b0, '0, '0, IQ_PASS, DIR_UP, 1'b0, '0);
        end
    endtask

    function automatic logic signed [SAMPLE_WIDTH-1:0] random_sample();
        return SAMPLE_WIDTH'($urandom);
    endfunction

    task automatic finish_run();
        int total_errors;
        total_errors = error_count
            + rx_channel_modulator_inst.rx_channel_modulator_properties_inst.assert_failures;
        $display("Summary: %0d tests, %0d sent, %0d received, %0d errors",
                 test_count, sent_count, out_count, total_errors);
        if (total_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    endtask

    task automatic wait_drain(input string test_name, input int errors_before);
        int waited;
        idle_cycles(1);
        waited = 0;
        while (exp_i_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
            @(negedge i_clock);
            waited++;
        end
        test_count++;
        if (exp_i_q.size() != 0) begin
            $display("Timeout in %s: %0d outputs never arrived", test_name, exp_i_q.size());
            error_count++;
            finish_run();
        end else begin
            $display("%s finished with %0d errors", test_name, error_count - errors_before);
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge i_clock) begin
        if (i_rst_n === 1'b1 && o_valid === 1'b1) begin
            out_count++;
            if (exp_i_q.size() == 0) begin
                $display("Unexpected output at %0t ns with no sample pending", $time);
                error_count++;
            end else begin
                compare_sample(o_inph, exp_i_q.pop_front(), "I");
                compare_sample(o_quad, exp_q_q.pop_front(), "Q");
                check_latency(cycle_count - in_cycle_q.pop_front());
            end
        end
    end

    task automatic test_zero_increment();
        int errors_before;
        errors_before = error_count;
        load_increment('0);
        send_sample(16'sd1000, -16'sd2000, IQ_PASS, DIR_UP);
        idle_cycles(6);
        send_sample(16'sd32767, -16'sd32768, IQ_PASS, DIR_UP);
        send_sample(16'sd0, 16'sd1, IQ_PASS, DIR_UP);
        send_sample(random_sample(), random_sample(), IQ_PASS, DIR_UP);
        wait_drain("zero_increment", errors_before);
    endtask

    task automatic test_rotation_burst();
        int errors_before;
        errors_before = error_count;
        load_increment(12'd37);
        repeat (24) begin
            send_sample(random_sample(), random_sample(), IQ_PASS, DIR_UP);
        end
        load_increment(12'd301);
        repeat (24) begin
            send_sample(random_sample(), random_sample(), IQ_PASS, DIR_DOWN);
        end
        wait_drain("rotation_burst", errors_before);
    endtask

    task automatic test_phase_reload();
        int errors_before;
        errors_before = error_count;
        load_increment(12'd100);
        repeat (5) begin
            send_sample(16'sd12000, 16'sd3000, IQ_PASS, DIR_UP);
        end
        // Load and sample together
        drive_cycle(1'b1, 16'sd12000, 16'sd3000, IQ_PASS, DIR_UP, 1'b1, 12'd200);
        repeat (4) begin
            send_sample(16'sd12000, 16'sd3000, IQ_PASS, DIR_UP);
        end
        load_increment(12'd900);
        repeat (3) begin
            send_sample(-16'sd7000, 16'sd15000, IQ_PASS, DIR_DOWN);
        end
        wait_drain("phase_reload", errors_before);
    endtask

    task automatic test_iq_ops();
        int errors_before;
        errors_before = error_count;
        load_increment('0);
        send_sample(16'sd1234, -16'sd4321, IQ_SWAP, DIR_UP);
        send_sample(16'sd1234, -16'sd4321, IQ_CONJ, DIR_UP);
        send_sample(16'sd500, -16'sd32768, IQ_CONJ, DIR_UP);
        send_sample(-16'sd32768, 16'sd32767, IQ_SWAP, DIR_UP);
        load_increment(12'd640);
        repeat (6) begin
            send_sample(random_sample(), random_sample(), IQ_SWAP, DIR_DOWN);
            send_sample(random_sample(), -16'sd32768, IQ_CONJ, DIR_UP);
        end
        wait_drain("iq_ops", errors_before);
    endtask

    // Second sample after each load sits at 45 degrees
    task automatic test_saturation();
        int errors_before;
        errors_before = error_count;
        load_increment(12'd512);
        send_sample(16'sd0, 16'sd0, IQ_PASS, DIR_UP);
        send_sample(16'sd32767, 16'sd32767, IQ_PASS, DIR_UP);
        load_increment(12'd512);
        send_sample(16'sd0, 16'sd0, IQ_PASS, DIR_UP);
        send_sample(-16'sd32768, -16'sd32768, IQ_PASS, DIR_UP);
        load_increment(12'd512);
        send_sample(16'sd0, 16'sd0, IQ_PASS, DIR_DOWN);
        send_sample(16'sd32767, 16'sd32767, IQ_PASS, DIR_DOWN);
        wait_drain("saturation", errors_before);
    endtask

    task automatic test_gapped_valid();
        int errors_before;
        int outs_before;
        int sent_before;
        errors_before = error_count;
        outs_before = out_count;
        sent_before = sent_count;
        load_increment(12'd77);
        for (int n = 0; n < 40; n++) begin
            if ($urandom_range(0, 2) == 0) begin
                // Junk data and config while idle
                drive_cycle(1'b0, random_sample(), random_sample(), IQ_CONJ, DIR_DOWN,
                            1'b0, '0);
            end else begin
                send_sample(random_sample(), random_sample(), IQ_PASS, DIR_UP);
            end
        end
        wait_drain("gapped_valid", errors_before);
        if (out_count - outs_before != sent_count - sent_before) begin
            $display("Output count mismatch: %0d outputs for %0d inputs",
                     out_count - outs_before, sent_count - sent_before);
            error_count++;
        end
    endtask

    initial begin
        i_rst_n           = 1'b1;
        i_valid           = 1'b0;
        i_inph            = '0;
        i_quad            = '0;
        i_phase_inc       = '0;
        i_phase_inc_valid = 1'b0;
        i_iq_op           = IQ_PASS;
        i_mix_dir         = DIR_UP;
        seed_value        = $urandom(SEED);
        #1;
        i_rst_n = 1'b0;
        repeat (3) @(posedge i_clock);
        @(negedge i_clock);
        i_rst_n = 1'b1;

        test_zero_increment();
        test_rotation_burst();
        test_phase_reload();
        test_iq_ops();
        test_saturation();
        test_gapped_valid();

        idle_cycles(8);
        finish_run();
    end

endmodule : tb_rx_channel_modulator

`default_nettype wire

// ==== verilog.f ====
nco_pkg.sv
chmod_pkg.sv
chmod_nco.sv
chmod_iq_front.sv
chmod_mixer.sv
rx_channel_modulator.sv
rx_channel_modulator_properties.sv
tb_rx_channel_modulator.sv
